// ==== design/laser_link_pkg.sv ====
package laser_link_pkg;

    // Link geometry
    localparam int NUM_LANES = 2;
    localparam int BYTE_W = 8;

    // Bit timing, in system clocks
    localparam int SAMPLES_PER_BIT = 8;
    localparam int VOTE_FIRST = 3;
    localparam int VOTE_LAST = 5;
    localparam int SAMPLE_POINT = 7;

    // Lead low, start high, then eight data slots LSB first
    localparam int TX_SLOTS = 10;
    // Start, eight data, stop low
    localparam int RX_SLOTS = 10;

    localparam int SAMPLE_W = $clog2(SAMPLES_PER_BIT);
    // One extra count so the transmitter can sit past its last slot
    localparam int SLOT_W = $clog2(TX_SLOTS + 1);

    // Lane 0 is the first laser
    typedef logic [NUM_LANES-1:0][BYTE_W-1:0] lane_bytes_t;

    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              frame_ok;
    } lane_result_t;

    typedef struct packed {
        lane_bytes_t          bytes;
        logic [NUM_LANES-1:0] ok;
    } rx_pair_t;

    typedef struct packed {
        logic vote_window;
        logic sample;
        logic frame_end;
    } rx_strobe_t;

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_DONE} tx_state_e;
    typedef enum logic {RX_WAIT, RX_RECEIVE} rx_state_e;
    typedef enum logic {MODE_SIMULTANEOUS, MODE_INDEPENDENT} lane_mode_e;

endpackage

// ==== design/laser_tx_pair.sv ====
`timescale 1ns/1ps

module laser_tx_pair (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        laser_en,
    input  logic                                        tx_start,
    input  laser_link_pkg::lane_bytes_t                 tx_bytes,
    output logic [laser_link_pkg::NUM_LANES-1:0][1:0]   laser_tx,
    output logic                                        tx_busy,
    output logic                                        tx_done
);
    import laser_link_pkg::*;

    tx_state_e                            state;
    logic [SAMPLE_W-1:0]                  sample_cnt;
    logic [SLOT_W-1:0]                    slot_cnt;
    lane_bytes_t                          tx_q;
    logic [NUM_LANES-1:0][TX_SLOTS-1:0]   frame_bits;
    logic [NUM_LANES-1:0]                 data_q;
    logic                                 accept;

    assign accept = (state == TX_IDLE) && laser_en && tx_start;

    // Byte pair held for the whole frame
    always_ff @(posedge clock) begin
        if (accept) begin
            tx_q <= tx_bytes;
        end
    end

    // Slot 0 is the idle-low lead and slot 1 the start bit
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            frame_bits[i] = {tx_q[i], 1'b1, 1'b0};
        end
    end

    // One bit timer shared by both lanes
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= TX_IDLE;
            sample_cnt <= '0;
            slot_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    sample_cnt <= '0;
                    slot_cnt <= '0;
                    if (accept) begin
                        state <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (!laser_en) begin
                        state <= TX_IDLE;
                    end else if (slot_cnt == SLOT_W'(TX_SLOTS)) begin
                        // Extra cycle lets the registered line finish the last slot
                        state <= TX_DONE;
                    end else if (sample_cnt == SAMPLE_W'(SAMPLES_PER_BIT - 1)) begin
                        sample_cnt <= '0;
                        slot_cnt <= slot_cnt + 1'b1;
                    end else begin
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Registered line drive that stays low outside a frame
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_q <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                data_q[i] <= (state == TX_SEND && slot_cnt < SLOT_W'(TX_SLOTS)) ?
                             frame_bits[i][slot_cnt] : 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            laser_tx[i] = {data_q[i], laser_en};
        end
    end

    assign tx_busy = (state == TX_SEND);
    assign tx_done = (state == TX_DONE);

    // Done closes a frame that kept busy high for every slot
    done_after_busy: assert property (@(posedge clock) disable iff (reset)
        tx_done |-> !tx_busy && $past(tx_busy) &&
                    $past(tx_busy, TX_SLOTS * SAMPLES_PER_BIT + 1) &&
                    !$past(tx_busy, TX_SLOTS * SAMPLES_PER_BIT + 2));

endmodule

// ==== design/rx_bit_timer.sv ====
`timescale 1ns/1ps

module rx_bit_timer (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [laser_link_pkg::NUM_LANES-1:0]  laser_rx,
    output logic [laser_link_pkg::NUM_LANES-1:0]  lane_bits,
    output laser_link_pkg::rx_strobe_t            strobes
);
    import laser_link_pkg::*;

    rx_state_e              state;
    logic [NUM_LANES-1:0]   sync_1;
    logic [NUM_LANES-1:0]   sync_2;
    logic [NUM_LANES-1:0]   prev;
    logic                   rise;
    logic                   receiving;
    logic [SAMPLE_W-1:0]    sample_cnt;
    logic [SLOT_W-1:0]      slot_cnt;

    // Two-flop synchronizer plus one flop for edge detection
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
            prev <= '0;
        end else begin
            sync_1 <= laser_rx;
            sync_2 <= sync_1;
            prev <= sync_2;
        end
    end

    assign lane_bits = sync_2;
    assign rise = |(sync_2 & ~prev);
    assign receiving = (state == RX_RECEIVE);

    // The edge cycle itself counts as sample 0 of the start slot
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= RX_WAIT;
            sample_cnt <= '0;
            slot_cnt <= '0;
        end else if (state == RX_WAIT) begin
            if (rise) begin
                state <= RX_RECEIVE;
                sample_cnt <= SAMPLE_W'(1);
                slot_cnt <= '0;
            end
        end else if (strobes.frame_end) begin
            state <= RX_WAIT;
        end else if (sample_cnt == SAMPLE_W'(SAMPLES_PER_BIT - 1)) begin
            sample_cnt <= '0;
            slot_cnt <= slot_cnt + 1'b1;
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    assign strobes.vote_window = receiving && sample_cnt >= SAMPLE_W'(VOTE_FIRST) &&
                                 sample_cnt <= SAMPLE_W'(VOTE_LAST);
    assign strobes.sample = receiving && sample_cnt == SAMPLE_W'(SAMPLE_POINT);
    assign strobes.frame_end = strobes.sample && slot_cnt == SLOT_W'(RX_SLOTS - 1);

    vote_before_sample: assert property (@(posedge clock) disable iff (reset)
        !(strobes.sample && strobes.vote_window));

endmodule

// ==== design/laser_rx_lane.sv ====
`timescale 1ns/1ps

module laser_rx_lane (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          lane_bit,
    input  laser_link_pkg::rx_strobe_t    strobes,
    output laser_link_pkg::lane_result_t  result
);
    import laser_link_pkg::*;

    logic [1:0]           vote_cnt;
    logic [RX_SLOTS-1:0]  shift_reg;
    logic [RX_SLOTS-1:0]  shift_next;

    // Counts highs over the three window samples, two of three wins
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            vote_cnt <= '0;
        end else if (strobes.sample) begin
            vote_cnt <= '0;
        end else if (strobes.vote_window && lane_bit) begin
            vote_cnt <= vote_cnt + 1'b1;
        end
    end

    // New bits enter at the top, so the start bit ends up in bit 0
    assign shift_next = {vote_cnt[1], shift_reg[RX_SLOTS-1:1]};

    always_ff @(posedge clock) begin
        if (strobes.sample) begin
            shift_reg <= shift_next;
        end
    end

    // Stop bit is still in the vote counter on the frame_end cycle
    assign result.data = shift_next[BYTE_W:1];
    assign result.frame_ok = strobes.frame_end && shift_next[0] && !shift_next[RX_SLOTS-1];

endmodule

// ==== design/rx_pair_merge.sv ====
`timescale 1ns/1ps

module rx_pair_merge (
    input  logic                          clock,
    input  logic                          reset,
    input  laser_link_pkg::lane_mode_e    mode,
    input  logic                          frame_end,
    input  laser_link_pkg::lane_result_t  lanes [laser_link_pkg::NUM_LANES],
    output logic                          data_valid,
    output laser_link_pkg::rx_pair_t      rx_pair
);
    import laser_link_pkg::*;

    logic [NUM_LANES-1:0] lane_ok;
    logic                 pass;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_ok[i] = lanes[i].frame_ok;
        end
    end

    // Test mode takes whatever lane made it through
    assign pass = (mode == MODE_SIMULTANEOUS) ? &lane_ok : |lane_ok;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_valid <= 1'b0;
            rx_pair <= '0;
        end else begin
            data_valid <= frame_end && pass;
            // Pair stays put until the next accepted frame
            if (frame_end && pass) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    rx_pair.bytes[i] <= lanes[i].data;
                end
                rx_pair.ok <= lane_ok;
            end
        end
    end

    valid_after_frame_end: assert property (@(posedge clock) disable iff (reset)
        data_valid |-> $past(frame_end));

endmodule

// ==== design/laser_link.sv ====
`timescale 1ns/1ps

module laser_link (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        tx_start,
    input  laser_link_pkg::lane_bytes_t                 tx_bytes,
    input  logic                                        laser_en,
    output logic [laser_link_pkg::NUM_LANES-1:0][1:0]   laser_tx,
    output logic                                        tx_busy,
    output logic                                        tx_done,
    input  logic [laser_link_pkg::NUM_LANES-1:0]        laser_rx,
    input  laser_link_pkg::lane_mode_e                  mode,
    output logic                                        data_valid,
    output laser_link_pkg::rx_pair_t                    rx_pair
);
    import laser_link_pkg::*;

    logic [NUM_LANES-1:0] lane_bits;
    rx_strobe_t           strobes;
    lane_result_t         lane_results [NUM_LANES];

    laser_tx_pair tx_pair_inst (
        .clock    (clock),
        .reset    (reset),
        .laser_en (laser_en),
        .tx_start (tx_start),
        .tx_bytes (tx_bytes),
        .laser_tx (laser_tx),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    rx_bit_timer bit_timer_inst (
        .clock     (clock),
        .reset     (reset),
        .laser_rx  (laser_rx),
        .lane_bits (lane_bits),
        .strobes   (strobes)
    );

    // One receiver per laser, all on the shared timer
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        laser_rx_lane rx_lane_inst (
            .clock    (clock),
            .reset    (reset),
            .lane_bit (lane_bits[i]),
            .strobes  (strobes),
            .result   (lane_results[i])
        );
    end

    rx_pair_merge merge_inst (
        .clock      (clock),
        .reset      (reset),
        .mode       (mode),
        .frame_end  (strobes.frame_end),
        .lanes      (lane_results),
        .data_valid (data_valid),
        .rx_pair    (rx_pair)
    );

endmodule

// ==== sim/laser_link_tb.sv ====
`timescale 1ns/1ps

module laser_link_tb;
    import laser_link_pkg::*;

    localparam int FRAME_CYCLES = TX_SLOTS * SAMPLES_PER_BIT;
    localparam int DONE_CYCLE = 1 + FRAME_CYCLES;
    localparam int WAIT_BOUND = FRAME_CYCLES + 30;
    localparam int MAX_VECTORS = 32;
    localparam logic [31:0] SEED = 32'h4a4f9de2;

    logic                       clock;
    logic                       reset;
    logic                       tx_start;
    lane_bytes_t                tx_bytes;
    logic                       laser_en;
    logic [NUM_LANES-1:0][1:0]  laser_tx;
    logic                       tx_busy;
    logic                       tx_done;
    logic [NUM_LANES-1:0]       laser_rx;
    lane_mode_e                 mode;
    logic                       data_valid;
    rx_pair_t                   rx_pair;

    // Loopback controls
    logic [NUM_LANES-1:0]       block_mask;
    logic [NUM_LANES-1:0]       glitch_mask;

    // Golden vectors
    logic [8*16-1:0]            vec_name [MAX_VECTORS];
    logic                       vec_mode [MAX_VECTORS];
    lane_bytes_t                vec_bytes [MAX_VECTORS];
    logic [NUM_LANES-1:0]       vec_block [MAX_VECTORS];
    logic                       vec_glitch [MAX_VECTORS];
    logic                       vec_valid [MAX_VECTORS];
    rx_pair_t                   vec_pair [MAX_VECTORS];
    int                         num_vectors;

    int                         cycle_count;
    int                         cycle_limit;
    logic [31:0]                rng_state;

    laser_link laser_link_inst (
        .clock      (clock),
        .reset      (reset),
        .tx_start   (tx_start),
        .tx_bytes   (tx_bytes),
        .laser_en   (laser_en),
        .laser_tx   (laser_tx),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done),
        .laser_rx   (laser_rx),
        .mode       (mode),
        .data_valid (data_valid),
        .rx_pair    (rx_pair)
    );

    always #20 clock = ~clock;

    // Blocked lanes read dark, a glitch flips the line for one cycle
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            laser_rx[i] = block_mask[i] ? 1'b0 : (laser_tx[i][1] ^ glitch_mask[i]);
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles without finishing", cycle_count);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_pair(input string name, input rx_pair_t expected,
                              input rx_pair_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Inputs change 2 ns after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic read_golden();
        int               fd;
        int               items;
        logic [8*128-1:0] line;
        logic [8*16-1:0]  f_name;
        logic [31:0]      f_mode;
        logic [31:0]      f_bytes;
        logic [31:0]      f_block;
        logic [31:0]      f_glitch;
        logic [31:0]      f_valid;
        logic [31:0]      f_pair;
        fd = $fopen("sim/laser_link_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            $display("Test FAILED");
            $fatal(1, "no vectors");
        end
        num_vectors = 0;
        while (!$feof(fd)) begin
            line = '0;
            items = $fgets(line, fd);
            // Comment and blank lines never match all seven fields
            if (items > 0 && num_vectors < MAX_VECTORS &&
                $sscanf(line, "%s %h %h %h %h %h %h", f_name, f_mode, f_bytes, f_block,
                        f_glitch, f_valid, f_pair) == 7) begin
                vec_name[num_vectors] = f_name;
                vec_mode[num_vectors] = f_mode[0];
                vec_bytes[num_vectors] = f_bytes[NUM_LANES*BYTE_W-1:0];
                vec_block[num_vectors] = f_block[NUM_LANES-1:0];
                vec_glitch[num_vectors] = f_glitch[0];
                vec_valid[num_vectors] = f_valid[0];
                vec_pair[num_vectors] = f_pair[$bits(rx_pair_t)-1:0];
                num_vectors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        check_bit("reset tx_busy", 1'b0, tx_busy);
        check_bit("reset tx_done", 1'b0, tx_done);
        check_bit("reset data_valid", 1'b0, data_valid);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_bit("reset laser data", 1'b0, laser_tx[i][1]);
            check_bit("reset laser power", laser_en, laser_tx[i][0]);
        end
        check_pair("reset rx_pair", '0, rx_pair);
    endtask

    task automatic run_vector(input int v);
        string name;
        int    n;
        int    glitch_cycle;
        int    glitch_lane;
        logic  valid_seen;
        name = $sformatf("%0s", vec_name[v]);
        glitch_cycle = -1;
        glitch_lane = 0;
        if (vec_glitch[v]) begin
            rng_state = xorshift(rng_state);
            // Data slot 2..9 and a voted sample; the line trails the slot count by one
            glitch_cycle = SAMPLES_PER_BIT * (2 + int'(rng_state % 8)) + 1 + VOTE_FIRST +
                           int'((rng_state >> 8) % (VOTE_LAST - VOTE_FIRST + 1));
            glitch_lane = int'((rng_state >> 16) % NUM_LANES);
        end
        mode = lane_mode_e'(vec_mode[v]);
        block_mask = vec_block[v];
        tx_bytes = vec_bytes[v];
        tx_start = 1'b1;
        next_cycle();
        check_bit({name, " tx_busy after start"}, 1'b1, tx_busy);
        tx_start = 1'b0;
        valid_seen = 1'b0;
        for (n = 1; n <= WAIT_BOUND; n++) begin
            next_cycle();
            glitch_mask = '0;
            glitch_mask[glitch_lane] = (n == glitch_cycle);
            // Second request while the frame is still going out
            tx_start = (n >= 20 && n < 30);
            check_bit({name, " tx_done"}, n == DONE_CYCLE, tx_done);
            check_bit({name, " tx_busy"}, n < DONE_CYCLE, tx_busy);
            for (int i = 0; i < NUM_LANES; i++) begin
                check_bit({name, " laser power"}, laser_en, laser_tx[i][0]);
            end
            if (data_valid) begin
                check_bit({name, " repeated data_valid"}, 1'b0, valid_seen);
                valid_seen = 1'b1;
            end
        end
        glitch_mask = '0;
        tx_start = 1'b0;
        check_bit({name, " data_valid"}, vec_valid[v], valid_seen);
        check_pair({name, " rx_pair"}, vec_pair[v], rx_pair);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        tx_start = 1'b0;
        tx_bytes = '0;
        laser_en = 1'b0;
        mode = MODE_SIMULTANEOUS;
        block_mask = '0;
        glitch_mask = '0;
        cycle_count = 0;
        rng_state = SEED;
        read_golden();
        if (num_vectors == 0) begin
            $display("The golden vector file holds no usable vectors");
            $display("Test FAILED");
            $fatal(1, "no vectors");
        end
        cycle_limit = num_vectors * (FRAME_CYCLES + 40) + 100;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        next_cycle();
        check_reset_state();
        laser_en = 1'b1;
        next_cycle();
        for (int v = 0; v < num_vectors; v++) begin
            run_vector(v);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== sim/laser_link_golden.txt ====
# name mode lane_bytes(lane1,lane0) block_mask glitch valid rx_pair(bytes,ok)
# values in hex; mode 0 simultaneous, 1 independent; block bit 1 holds lane 1 low
sim_5a3c 0 5a3c 0 0 1 168f3
sim_ff00 0 ff00 0 0 1 3fc03
sim_0181 0 0181 0 0 1 00607
gl_a55a 0 a55a 0 1 1 2956b
gl_c3e7 1 c3e7 0 1 1 30f9f
blk_ind 1 7e3c 2 0 1 000f1
blk_sim 0 4d96 2 0 0 000f1
gl_0ff0 0 0ff0 0 1 1 03fc3
ind_full 1 1234 0 0 1 048d3

// ==== tb.f ====
design/laser_link_pkg.sv
design/laser_tx_pair.sv
design/rx_bit_timer.sv
design/laser_rx_lane.sv
design/rx_pair_merge.sv
design/laser_link.sv
sim/laser_link_tb.sv
